//--- src/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [29:0] ptr;
	typedef logic [3:0]  cond_code;
	typedef logic [3:0]  alu_op;
	typedef logic [2:0]  op_group;
	typedef logic [1:0]  shift_type;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// condition encodings, bits 31:28 of every instruction.
	localparam cond_code EQ = 4'h0, NE = 4'h1, CS = 4'h2, CC = 4'h3;
	localparam cond_code MI = 4'h4, PL = 4'h5, VS = 4'h6, VC = 4'h7;
	localparam cond_code HI = 4'h8, LS = 4'h9, GE = 4'ha, LT = 4'hb;
	localparam cond_code GT = 4'hc, LE = 4'hd, AL = 4'he, NV = 4'hf;

	localparam alu_op AND = 4'h0, EOR = 4'h1, SUB = 4'h2, RSB = 4'h3;
	localparam alu_op ADD = 4'h4, ADC = 4'h5, SBC = 4'h6, RSC = 4'h7;
	localparam alu_op TST = 4'h8, TEQ = 4'h9, CMP = 4'ha, CMN = 4'hb;
	localparam alu_op ORR = 4'hc, MOV = 4'hd, BIC = 4'he, MVN = 4'hf;

	localparam shift_type SHIFT_LSL = 2'b00, SHIFT_LSR = 2'b01;
	localparam shift_type SHIFT_ASR = 2'b10, SHIFT_ROR = 2'b11;

	// bits 27:25 select the instruction group.
	localparam op_group GROUP_ALU_REG  = 3'b000;
	localparam op_group GROUP_ALU_IMM  = 3'b001;
	localparam op_group GROUP_LDST_IMM = 3'b010;
	localparam op_group GROUP_LDST_REG = 3'b011;
	localparam op_group GROUP_B        = 3'b101;

	localparam int COND_HI = 31, COND_LO = 28;
	localparam int OP_HI = 27, OP_LO = 25;
	localparam int OPCODE_HI = 24, OPCODE_LO = 21;
	localparam int RN_HI = 19, RN_LO = 16;
	localparam int RD_HI = 15, RD_LO = 12;
	localparam int RS_HI = 11, RS_LO = 8;
	localparam int RM_HI = 3, RM_LO = 0;
	localparam int ROT_HI = 11, ROT_LO = 8;
	localparam int IMM8_HI = 7, IMM8_LO = 0;
	localparam int IMM12_HI = 11, IMM12_LO = 0;
	localparam int SHIFT_IMM_HI = 11, SHIFT_IMM_LO = 7;
	localparam int SHIFT_TYPE_HI = 6, SHIFT_TYPE_LO = 5;
	localparam int BOFF_HI = 23, BOFF_LO = 0;
	localparam int I_BIT = 25, S_BIT = 20, LINK_BIT = 24;
	localparam int SHIFT_REG_BIT = 4, MUL_BIT = 7;
	localparam int P_BIT = 24, U_BIT = 23, B_BIT = 22, W_BIT = 21, L_BIT = 20;

	localparam reg_num R14 = 4'd14;

	typedef struct packed {
		logic      is_imm;
		logic      [11:0] imm;
		reg_num    r;
		logic      [4:0] shift_imm;
		logic      shift_by_reg;
		reg_num    r_shift;
		logic      shr;
		logic      ror;
		shift_type shift;
	} snd_decode;

	typedef struct packed {
		alu_op  op;
		reg_num rn;
		reg_num rd;
		logic   uses_carry;
	} data_decode;

	typedef struct packed {
		logic   enable;
		logic   load;
		logic   byte_xfer;
		logic   pre_index;
		logic   increment;
		logic   writeback;
		reg_num rn;
		reg_num rd;
	} ldst_decode;

endpackage

//--- src/core_decode_conds.sv
`timescale 1ns/1ns

module core_decode_conds (
	input  logic [3:0]         cond,
	input  core_pkg::psr_flags flags,
	output logic               execute,
	output logic               undefined
);

	always_comb begin
		undefined = 1'b0;
		unique case (cond)
			core_pkg::EQ: execute = flags.z;
			core_pkg::NE: execute = !flags.z;
			core_pkg::CS: execute = flags.c;
			core_pkg::CC: execute = !flags.c;
			core_pkg::MI: execute = flags.n;
			core_pkg::PL: execute = !flags.n;
			core_pkg::VS: execute = flags.v;
			core_pkg::VC: execute = !flags.v;
			core_pkg::HI: execute = flags.c && !flags.z; // unsigned higher.
			core_pkg::LS: execute = !flags.c || flags.z;
			core_pkg::GE: execute = flags.n == flags.v; // signed compares.
			core_pkg::LT: execute = flags.n != flags.v;
			core_pkg::GT: execute = !flags.z && (flags.n == flags.v);
			core_pkg::LE: execute = flags.z || (flags.n != flags.v);
			core_pkg::AL: execute = 1'b1;
			default: begin
				// NV is reserved on this core.
				execute = 1'b0;
				undefined = 1'b1;
			end
		endcase
	end

endmodule

//--- src/core_decode_snd.sv
`timescale 1ns/1ns

module core_decode_snd (
	input  core_pkg::word       insn,
	input  logic                is_imm,
	input  logic                ror_if_imm,
	input  logic                shift_by_reg_if_reg,
	output core_pkg::snd_decode decode,
	output logic                undefined
);

	logic reg_shift;

	assign reg_shift = insn[core_pkg::SHIFT_REG_BIT];

	always_comb begin
		decode = '0;
		decode.is_imm = is_imm;

		if (is_imm) begin
			if (ror_if_imm) begin
				decode.imm = {4'b0, insn[core_pkg::IMM8_HI:core_pkg::IMM8_LO]};
				decode.shift_imm = {insn[core_pkg::ROT_HI:core_pkg::ROT_LO], 1'b0};
				decode.shr = 1'b1;
				decode.ror = 1'b1;
				decode.shift = core_pkg::SHIFT_ROR;
			end else
				decode.imm = insn[core_pkg::IMM12_HI:core_pkg::IMM12_LO]; // plain offset.
		end else begin
			decode.r = insn[core_pkg::RM_HI:core_pkg::RM_LO];
			decode.shift = insn[core_pkg::SHIFT_TYPE_HI:core_pkg::SHIFT_TYPE_LO];
			decode.shift_by_reg = reg_shift && shift_by_reg_if_reg;
			decode.r_shift = insn[core_pkg::RS_HI:core_pkg::RS_LO];
			if (!decode.shift_by_reg)
				decode.shift_imm = insn[core_pkg::SHIFT_IMM_HI:core_pkg::SHIFT_IMM_LO];
			decode.shr = decode.shift != core_pkg::SHIFT_LSL;
			// the shifter treats ROR with a zero amount as RRX.
			decode.ror = decode.shift == core_pkg::SHIFT_ROR;
		end
	end

	assign undefined = !is_imm && reg_shift && !shift_by_reg_if_reg;

endmodule

//--- src/core_decode_data.sv
`timescale 1ns/1ns

module core_decode_data (
	input  core_pkg::word        insn,
	output core_pkg::data_decode decode,
	output logic                 writeback,
	output logic                 update_flags,
	output logic                 snd_is_imm,
	output logic                 snd_shift_by_reg_if_reg,
	output logic                 uses_rn
);

	core_pkg::alu_op op;

	assign op = insn[core_pkg::OPCODE_HI:core_pkg::OPCODE_LO];

	always_comb begin
		decode.op = op;
		decode.rn = insn[core_pkg::RN_HI:core_pkg::RN_LO];
		decode.rd = insn[core_pkg::RD_HI:core_pkg::RD_LO];

		// the carry-in comes from the C flag only for these three.
		unique case (op)
			core_pkg::ADC, core_pkg::SBC, core_pkg::RSC:
				decode.uses_carry = 1'b1;
			default:
				decode.uses_carry = 1'b0;
		endcase

		writeback = 1'b1;
		uses_rn = 1'b1;
		unique case (op)
			core_pkg::TST, core_pkg::TEQ, core_pkg::CMP, core_pkg::CMN:
				writeback = 1'b0; // result only goes to the flags.
			core_pkg::MOV, core_pkg::MVN:
				uses_rn = 1'b0;
			default: ;
		endcase
	end

	assign update_flags = insn[core_pkg::S_BIT];
	assign snd_is_imm = insn[core_pkg::I_BIT];

	// register operands may take their shift amount from rs.
	assign snd_shift_by_reg_if_reg = !insn[core_pkg::I_BIT];

endmodule

//--- src/core_decode_ldst_single.sv
`timescale 1ns/1ns

module core_decode_ldst_single (
	input  core_pkg::word        insn,
	output logic                 snd_is_imm,
	output core_pkg::ldst_decode decode
);

	logic pre_index;
	logic base_wb;

	assign pre_index = insn[core_pkg::P_BIT];
	assign base_wb = insn[core_pkg::W_BIT];

	// the I bit has the opposite sense of the data-processing one.
	assign snd_is_imm = !insn[core_pkg::I_BIT];

	always_comb begin
		decode.enable = 1'b1;
		decode.load = insn[core_pkg::L_BIT];
		decode.byte_xfer = insn[core_pkg::B_BIT];
		decode.pre_index = pre_index;
		decode.increment = insn[core_pkg::U_BIT];

		// post-indexed transfers always update the base.
		decode.writeback = base_wb || !pre_index;

		decode.rn = insn[core_pkg::RN_HI:core_pkg::RN_LO];
		decode.rd = insn[core_pkg::RD_HI:core_pkg::RD_LO];
	end

endmodule

//--- src/core_decode_ldst_addr.sv
`timescale 1ns/1ns

module core_decode_ldst_addr (
	input  core_pkg::ldst_decode ldst,
	output core_pkg::data_decode alu
);

	// post-index runs the same ALU op because the base update is done after the access.
	always_comb begin
		if (ldst.increment)
			alu.op = core_pkg::ADD;
		else
			alu.op = core_pkg::SUB;

		alu.rn = ldst.rn;
		alu.rd = ldst.rn; // the new base goes back to rn.
		alu.uses_carry = 1'b0;
	end

endmodule

//--- src/core_decode.sv
`timescale 1ns/1ns

module core_decode (
	input  core_pkg::word        insn,
	input  core_pkg::psr_flags   flags,
	output logic                 execute,
	output logic                 conditional,
	output logic                 undefined,
	output logic                 writeback,
	output logic                 update_flags,
	output logic                 uses_rn,
	output logic                 branch,
	output core_pkg::ptr         branch_offset,
	output core_pkg::snd_decode  snd_ctrl,
	output core_pkg::data_decode data_ctrl,
	output core_pkg::ldst_decode ldst_ctrl
);

	core_pkg::op_group group;
	logic cond_execute, cond_undefined;
	logic snd_is_imm, snd_ror_if_imm, snd_shift_by_reg_if_reg, snd_undefined;
	logic is_ldst, alu_ok;
	logic data_writeback, data_update_flags, data_is_imm;
	logic data_shift_by_reg_if_reg, data_uses_rn;
	logic ldst_is_imm;
	core_pkg::snd_decode  snd;
	core_pkg::data_decode data;
	core_pkg::data_decode data_ldst;
	core_pkg::ldst_decode ldst_single;

	assign group = insn[core_pkg::OP_HI:core_pkg::OP_LO];
	assign is_ldst = insn[core_pkg::OP_HI:core_pkg::OP_HI - 1] == 2'b01;

	core_decode_conds conds (
		.cond(insn[core_pkg::COND_HI:core_pkg::COND_LO]),
		.flags(flags),
		.execute(cond_execute),
		.undefined(cond_undefined)
	);

	// load/store offsets are never rotated and never shifted by a register.
	assign snd_is_imm = is_ldst ? ldst_is_imm : data_is_imm;
	assign snd_ror_if_imm = !is_ldst;
	assign snd_shift_by_reg_if_reg = is_ldst ? 1'b0 : data_shift_by_reg_if_reg;

	core_decode_snd snd_operand (
		.insn(insn),
		.is_imm(snd_is_imm),
		.ror_if_imm(snd_ror_if_imm),
		.shift_by_reg_if_reg(snd_shift_by_reg_if_reg),
		.decode(snd),
		.undefined(snd_undefined)
	);

	core_decode_data group_data (
		.insn(insn),
		.decode(data),
		.writeback(data_writeback),
		.update_flags(data_update_flags),
		.snd_is_imm(data_is_imm),
		.snd_shift_by_reg_if_reg(data_shift_by_reg_if_reg),
		.uses_rn(data_uses_rn)
	);

	core_decode_ldst_single group_ldst_single (
		.insn(insn),
		.snd_is_imm(ldst_is_imm),
		.decode(ldst_single)
	);

	core_decode_ldst_addr ldst2data (
		.ldst(ldst_single),
		.alu(data_ldst)
	);

	// multiply and swap sit in the register group with bits 7 and 4 set.
	// a test or compare without S is a PSR transfer or BX.
	assign alu_ok = !(group == core_pkg::GROUP_ALU_REG
	                  && insn[core_pkg::MUL_BIT] && insn[core_pkg::SHIFT_REG_BIT])
	                && (data_writeback || data_update_flags);

	assign conditional = insn[core_pkg::COND_HI:core_pkg::COND_LO] != core_pkg::AL;
	assign branch_offset = {{6{insn[core_pkg::BOFF_HI]}},
	                        insn[core_pkg::BOFF_HI:core_pkg::BOFF_LO]};

	always_comb begin
		execute = cond_execute;
		undefined = cond_undefined;
		branch = 1'b0;
		writeback = 1'b0;
		update_flags = 1'b0;
		uses_rn = 1'b1;
		snd_ctrl = '0;
		data_ctrl = '0;
		ldst_ctrl = '0;

		unique case (group)
			core_pkg::GROUP_B: begin
				branch = 1'b1;
				if (insn[core_pkg::LINK_BIT]) begin
					data_ctrl.rd = core_pkg::R14;
					writeback = 1'b1;
				end
			end
			core_pkg::GROUP_ALU_REG, core_pkg::GROUP_ALU_IMM: begin
				snd_ctrl = snd;
				data_ctrl = data;
				uses_rn = data_uses_rn;
				writeback = data_writeback;
				update_flags = data_update_flags;
				undefined = undefined || snd_undefined || !alu_ok;
			end
			core_pkg::GROUP_LDST_IMM, core_pkg::GROUP_LDST_REG: begin
				snd_ctrl = snd;
				ldst_ctrl = ldst_single;
				data_ctrl = data_ldst;
				writeback = ldst_single.writeback || ldst_single.load;
				undefined = undefined || snd_undefined;
			end
			default: undefined = 1'b1;
		endcase

		if (undefined) begin
			execute = 1'b0;
			branch = 1'bx;
			writeback = 1'bx;
			update_flags = 1'bx;
			uses_rn = 1'bx;
			snd_ctrl = 'x;
			data_ctrl = 'x;
			ldst_ctrl = 'x;
		end
	end

endmodule

//--- src/core_decode_stage.sv
`timescale 1ns/1ns

module core_decode_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 insn_valid,
	input  core_pkg::word        insn,
	input  core_pkg::psr_flags   flags,
	output logic                 out_valid,
	output logic                 execute,
	output logic                 conditional,
	output logic                 undefined,
	output logic                 writeback,
	output logic                 update_flags,
	output logic                 uses_rn,
	output logic                 branch,
	output core_pkg::ptr         branch_offset,
	output core_pkg::snd_decode  snd_ctrl,
	output core_pkg::data_decode data_ctrl,
	output core_pkg::ldst_decode ldst_ctrl
);

	logic dec_execute, dec_conditional, dec_undefined, dec_writeback;
	logic dec_update_flags, dec_uses_rn, dec_branch;
	core_pkg::ptr         dec_branch_offset;
	core_pkg::snd_decode  dec_snd;
	core_pkg::data_decode dec_data;
	core_pkg::ldst_decode dec_ldst;

	core_decode dec (
		.insn(insn),
		.flags(flags),
		.execute(dec_execute),
		.conditional(dec_conditional),
		.undefined(dec_undefined),
		.writeback(dec_writeback),
		.update_flags(dec_update_flags),
		.uses_rn(dec_uses_rn),
		.branch(dec_branch),
		.branch_offset(dec_branch_offset),
		.snd_ctrl(dec_snd),
		.data_ctrl(dec_data),
		.ldst_ctrl(dec_ldst)
	);

	// an undefined word carries no meaningful controls, so they are cleared.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			execute <= 1'b0;
			conditional <= 1'b0;
			undefined <= 1'b0;
			writeback <= 1'b0;
			update_flags <= 1'b0;
			uses_rn <= 1'b0;
			branch <= 1'b0;
			ldst_ctrl <= '0;
		end else begin
			out_valid <= insn_valid;
			if (insn_valid) begin
				execute <= dec_execute;
				conditional <= dec_conditional;
				undefined <= dec_undefined;
				writeback <= !dec_undefined && dec_writeback;
				update_flags <= !dec_undefined && dec_update_flags;
				uses_rn <= !dec_undefined && dec_uses_rn;
				branch <= !dec_undefined && dec_branch;
				ldst_ctrl <= dec_undefined ? '0 : dec_ldst;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (insn_valid) begin
			branch_offset <= dec_branch_offset;
			snd_ctrl <= dec_undefined ? '0 : dec_snd;
			data_ctrl <= dec_undefined ? '0 : dec_data;
		end
	end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = !clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#2 rst_n = 1'b1; // released in step with the other inputs.
	end

endmodule

//--- testbench/core_decode_tb.sv
`timescale 1ns/1ns

module core_decode_tb;

	typedef struct packed {
		logic execute, conditional, undefined, writeback, update_flags, uses_rn, branch;
		core_pkg::ptr         branch_offset;
		core_pkg::snd_decode  snd;
		core_pkg::data_decode data;
		core_pkg::ldst_decode ldst;
	} decode_result;

	// instruction counts of the tests, plus a few drain cycles each.
	localparam int RUN_CYCLES = 12 + 256 + 20 + 100 + 100 + 100 + 20 + 7 * 3;
	localparam int CYCLE_LIMIT = RUN_CYCLES + 200;

	logic clk, rst_n, insn_valid;
	core_pkg::word insn;
	core_pkg::psr_flags flags;
	logic out_valid, execute, conditional, undefined, writeback, update_flags, uses_rn, branch;
	core_pkg::ptr branch_offset;
	core_pkg::snd_decode snd_ctrl;
	core_pkg::data_decode data_ctrl;
	core_pkg::ldst_decode ldst_ctrl;
	decode_result expected_out;
	logic expected_valid;
	int seed, errors, issued, test_errors, tests_passed, tests_failed, cycle_count;

	tb_clock clock_gen (.clk(clk), .rst_n(rst_n));

	core_decode_stage DUT (
		.clk(clk), .rst_n(rst_n), .insn_valid(insn_valid), .insn(insn), .flags(flags),
		.out_valid(out_valid), .execute(execute), .conditional(conditional),
		.undefined(undefined), .writeback(writeback), .update_flags(update_flags),
		.uses_rn(uses_rn), .branch(branch), .branch_offset(branch_offset),
		.snd_ctrl(snd_ctrl), .data_ctrl(data_ctrl), .ldst_ctrl(ldst_ctrl)
	);

	function automatic logic cond_holds(input logic [3:0] c, input core_pkg::psr_flags f);
		logic base;
		case (c[3:1]) // odd codes are the negation of the even code below them.
			3'd0: base = f.z;
			3'd1: base = f.c;
			3'd2: base = f.n;
			3'd3: base = f.v;
			3'd4: base = f.c && !f.z;
			3'd5: base = f.n == f.v;
			3'd6: base = !f.z && (f.n == f.v);
			default: base = 1'b1;
		endcase
		return c[0] ? !base : base;
	endfunction

	function automatic core_pkg::snd_decode operand(input core_pkg::word w, input logic imm,
			input logic alu_form);
		core_pkg::snd_decode s;
		s = '0;
		s.is_imm = imm;
		if (imm && alu_form) begin
			s.imm = {4'h0, w[7:0]};
			s.shift_imm = {w[11:8], 1'b0}; // rotate right by twice the field.
			s.shr = 1'b1;
			s.ror = 1'b1;
			s.shift = core_pkg::SHIFT_ROR;
		end else if (imm) begin
			s.imm = w[11:0];
		end else begin
			s.r = w[3:0];
			s.shift = w[6:5];
			s.r_shift = w[11:8];
			s.shift_by_reg = w[4];
			if (!w[4])
				s.shift_imm = w[11:7];
			s.shr = w[6:5] != 2'b00;
			s.ror = w[6:5] == 2'b11;
		end
		return s;
	endfunction

	function automatic decode_result predict(input core_pkg::word w, input core_pkg::psr_flags f);
		decode_result r;
		logic undef;
		r = '0;
		undef = w[31:28] == core_pkg::NV;
		if (w[27:25] == 3'b101) begin
			r.branch = 1'b1;
			r.uses_rn = 1'b1;
			if (w[24]) begin
				r.data.rd = core_pkg::R14;
				r.writeback = 1'b1;
			end
		end else if (w[27:26] == 2'b00) begin
			r.data.op = w[24:21];
			r.data.rn = w[19:16];
			r.data.rd = w[15:12];
			r.data.uses_carry = r.data.op inside {core_pkg::ADC, core_pkg::SBC, core_pkg::RSC};
			r.writeback = !(r.data.op inside {core_pkg::TST, core_pkg::TEQ,
				core_pkg::CMP, core_pkg::CMN});
			r.update_flags = w[20];
			r.uses_rn = !(r.data.op inside {core_pkg::MOV, core_pkg::MVN});
			r.snd = operand(w, w[25], 1'b1);
			if (!w[25] && w[7] && w[4])
				undef = 1'b1; // multiply and swap space.
			if (!r.writeback && !w[20])
				undef = 1'b1;
		end else if (w[27:26] == 2'b01) begin
			r.ldst = {1'b1, w[20], w[22], w[24], w[23], w[21] || !w[24], w[19:16], w[15:12]};
			r.data.op = w[23] ? core_pkg::ADD : core_pkg::SUB;
			r.data.rn = w[19:16];
			r.data.rd = w[19:16];
			r.writeback = r.ldst.writeback || r.ldst.load;
			r.uses_rn = 1'b1;
			r.snd = operand(w, !w[25], 1'b0);
			if (w[25] && w[4])
				undef = 1'b1;
		end else
			undef = 1'b1;
		if (undef) begin
			r = '0;
			r.undefined = 1'b1;
		end else
			r.execute = cond_holds(w[31:28], f);
		r.conditional = w[31:28] != core_pkg::AL;
		r.branch_offset = {{6{w[23]}}, w[23:0]};
		return r;
	endfunction

	function automatic core_pkg::word random_word();
		return $random(seed);
	endfunction

	function automatic logic [3:0] random_cond();
		core_pkg::word r;
		r = $unsigned(random_word()) % 32'd15; // any code but NV.
		return r[3:0];
	endfunction

	function automatic core_pkg::word alu_word(input logic [3:0] cond);
		core_pkg::word w;
		w = random_word();
		w[31:26] = {cond, 2'b00};
		if (!w[25] && w[4])
			w[7] = 1'b0;
		if (w[24:23] == 2'b10)
			w[20] = 1'b1; // compares and tests always set the flags.
		return w;
	endfunction

	function automatic core_pkg::word ldst_word(input logic reg_shifted);
		core_pkg::word w;
		w = random_word();
		w[31:26] = {random_cond(), 2'b01};
		if (reg_shifted)
			{w[25], w[4]} = 2'b11;
		else if (w[25])
			w[4] = 1'b0;
		return w;
	endfunction

	function automatic core_pkg::word branch_word();
		core_pkg::word w;
		w = random_word();
		w[31:25] = {random_cond(), 3'b101};
		return w;
	endfunction

	function automatic core_pkg::word unsupported_word(input int kind);
		core_pkg::word w;
		w = random_word();
		case (kind)
			0: {w[27:22], w[7:4]} = {6'b000000, 4'b1001}; // multiply.
			1: {w[27:23], w[21:20], w[11:4]} = {5'b00010, 2'b00, 8'b00001001}; // swap.
			2: w[27:24] = 4'b1110;
			3: w[27:25] = 3'b110;
			default: w[27:24] = 4'b1111;
		endcase
		w[31:28] = random_cond();
		return w;
	endfunction

	task automatic report_value(input string name, input logic [31:0] want, input logic [31:0] got);
		$display("[FAIL] %0t ns %s expected %h got %h", $time, name, want, got);
		errors++;
	endtask

	task automatic issue(input core_pkg::word w, input core_pkg::psr_flags f);
		@(posedge clk);
		#2;
		insn_valid = 1'b1;
		insn = w;
		flags = f;
		issued++;
	endtask

	task automatic finish_test(input string name);
		repeat (2) begin
			@(posedge clk);
			#2 insn_valid = 1'b0;
		end
		@(negedge clk);
		$display("test %s done, %0d instructions, %0d errors", name, issued, errors - test_errors);
		if (errors == test_errors)
			tests_passed++;
		else
			tests_failed++;
		test_errors = errors;
		issued = 0;
	endtask

	task automatic check_quiet();
		assert (!out_valid) else report_value("out_valid", 0, out_valid);
		assert (!execute) else report_value("execute", 0, execute);
		assert (!writeback) else report_value("writeback", 0, writeback);
		assert (!branch) else report_value("branch", 0, branch);
	endtask

	// the model follows the stage by one cycle, like the DUT registers.
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			expected_valid <= 1'b0;
		else begin
			expected_valid <= insn_valid;
			if (insn_valid)
				expected_out <= predict(insn, flags);
		end
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	valid_in_step: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid == expected_valid) else report_value("out_valid", expected_valid, out_valid);
	execute_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> execute == expected_out.execute)
		else report_value("execute", expected_out.execute, execute);
	conditional_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> conditional == expected_out.conditional)
		else report_value("conditional", expected_out.conditional, conditional);
	undefined_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> undefined == expected_out.undefined)
		else report_value("undefined", expected_out.undefined, undefined);
	writeback_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> writeback == expected_out.writeback)
		else report_value("writeback", expected_out.writeback, writeback);
	update_flags_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> update_flags == expected_out.update_flags)
		else report_value("update_flags", expected_out.update_flags, update_flags);
	uses_rn_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> uses_rn == expected_out.uses_rn)
		else report_value("uses_rn", expected_out.uses_rn, uses_rn);
	branch_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> branch == expected_out.branch)
		else report_value("branch", expected_out.branch, branch);
	offset_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> branch_offset == expected_out.branch_offset)
		else report_value("branch_offset", expected_out.branch_offset, branch_offset);
	snd_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> snd_ctrl == expected_out.snd)
		else report_value("snd_ctrl", expected_out.snd, snd_ctrl);
	data_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> data_ctrl == expected_out.data)
		else report_value("data_ctrl", expected_out.data, data_ctrl);
	ldst_ok: assert property (@(negedge clk) disable iff (!rst_n)
		out_valid |-> ldst_ctrl == expected_out.ldst)
		else report_value("ldst_ctrl", expected_out.ldst, ldst_ctrl);

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		insn_valid = 1'b0;
		insn = '0;
		flags = '0;
		seed = 32'h9af7857d;

		repeat (9) begin
			@(negedge clk);
			check_quiet();
		end
		wait (rst_n);
		@(negedge clk);
		check_quiet();
		finish_test("reset");

		for (int c = 0; c < 16; c++)
			for (int f = 0; f < 16; f++)
				issue(alu_word(c[3:0]), f[3:0]);
		finish_test("conditions");

		repeat (20) issue(branch_word(), random_cond());
		finish_test("branches");

		repeat (100) issue(alu_word(random_cond()), random_cond());
		finish_test("data");

		for (int i = 0; i < 100; i++)
			issue(ldst_word(i % 8 == 7), random_cond());
		finish_test("load_store");

		for (int i = 0; i < 100; i++) begin
			case ($unsigned(random_word()) % 32'd4)
				0: issue(alu_word(random_cond()), random_cond());
				1: issue(ldst_word(1'b0), random_cond());
				2: issue(branch_word(), random_cond());
				default: issue(unsupported_word(i % 5), random_cond());
			endcase
		end
		finish_test("streaming");

		for (int i = 0; i < 20; i++)
			issue(unsupported_word(i % 5), random_cond());
		finish_test("unsupported");

		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- compile.f
src/core_pkg.sv
src/core_decode_conds.sv
src/core_decode_snd.sv
src/core_decode_data.sv
src/core_decode_ldst_single.sv
src/core_decode_ldst_addr.sv
src/core_decode.sv
src/core_decode_stage.sv
testbench/tb_clock.sv
testbench/core_decode_tb.sv

//--- run.sh
#!/bin/bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module core_decode_tb -Mdir obj_dir -o core_decode_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/core_decode_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
